// ==== verilog/mxv_pkg.sv ====
package mxv_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////
	localparam int N_MAX  = 8;   // largest matrix order
	localparam int NUM_PE = 4;   // processing elements in the line
	localparam int ELEM_W = 8;
	localparam int ACC_W  = 16;  // wraps mod 65536

	typedef logic [ELEM_W-1:0] elem_t;  // matrix or vector element
	typedef logic [ACC_W-1:0]  acc_t;   // dot product
	typedef logic [3:0]        n_t;     // order 1..8
	typedef logic [2:0]        row_t;   // row 0..7

	//////////////////////////////////////////////////
	// bundles
	//////////////////////////////////////////////////
	typedef struct packed {
		logic [N_MAX:0] push;  // bit r -> row r fifo, bit 8 -> vector
		elem_t          data;
	} load_t;

	typedef struct packed {
		logic valid;  // one cycle, end of a row
		acc_t acc;
	} pe_result_t;

	typedef struct packed {
		logic we;
		row_t addr;
		acc_t data;
	} res_wr_t;

	typedef struct packed {
		logic valid;
		acc_t data;
	} tx_t;

endpackage

// ==== verilog/mxv_counter.sv ====
`timescale 1ns/1ps

// up-counter, stops at terminal, clear wins over enable
module mxv_counter #(
	parameter int WIDTH = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             en,
	input  logic             clr,
	input  logic [WIDTH-1:0] terminal,
	output logic [WIDTH-1:0] count,
	output logic             at_terminal
);

	assign at_terminal = (count == terminal);  // combinational flag

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (clr) begin
			count <= '0;  // clear first
		end else if (en && !at_terminal) begin
			count <= count + 1'b1;
		end
		// otherwise hold, also at terminal
	end

endmodule

// ==== verilog/mxv_control.sv ====
`timescale 1ns/1ps

module mxv_control
import mxv_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  n_t   n,
	input  n_t   step_count,  // round step from counter
	input  logic step_done,   // step == n+3
	input  logic read_done,   // read addr == n-1
	output logic step_en,
	output logic step_clr,
	output logic read_en,
	output logic read_clr,
	output logic feed_en,
	output logic round_sel,
	output logic busy,
	output logic tx_valid,
	output logic done
);

	typedef enum logic [2:0] {
		st_idle,
		st_round0,  // rows 0..3
		st_round1,  // rows 4..7, only for n > 4
		st_send,
		st_finish
	} state_t;

	state_t state, state_nxt;
	logic   in_round;

	assign in_round = (state == st_round0) || (state == st_round1);

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////
	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:   if (start) state_nxt = st_round0;  // start ignored elsewhere
			st_round0: begin
				if (step_done) begin
					state_nxt = (n > n_t'(NUM_PE)) ? st_round1 : st_send;
				end
			end
			st_round1: if (step_done) state_nxt = st_send;
			st_send:   if (read_done) state_nxt = st_finish;  // n reads issued
			st_finish: state_nxt = st_idle;
			default:   state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= st_idle;
			tx_valid <= 1'b0;
			done     <= 1'b0;
		end else begin
			state    <= state_nxt;
			tx_valid <= read_en;                 // lines up with registered ram read
			done     <= (state == st_finish);  // lands in idle, busy already low
		end
	end

	// each round is n+4 steps, counter restarts at 0 for the next one
	assign step_en   = in_round;
	assign step_clr  = !in_round || step_done;
	assign feed_en   = in_round && (step_count < n);  // steps 0..n-1
	assign round_sel = (state == st_round1);

	assign read_en  = (state == st_send);
	assign read_clr = (state == st_idle);
	assign busy     = (state != st_idle);

	// order held for the whole op, rounds and send both depend on it
	a_n_stable: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> $stable(n));

endmodule

// ==== verilog/mxv_row_fifo.sv ====
`timescale 1ns/1ps

module mxv_row_fifo
import mxv_pkg::*;
#(
	parameter int DEPTH = 8
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  push,
	input  logic  pop,
	input  elem_t wdata,
	output elem_t rdata,
	output logic  empty,
	output logic  full
);

	localparam int PTR_W = $clog2(DEPTH);

	elem_t            mem [DEPTH];
	logic [PTR_W-1:0] wptr, rptr;
	logic [PTR_W:0]   count;  // 0..DEPTH

	assign rdata = mem[rptr];  // head visible in the pop cycle
	assign empty = (count == '0);
	assign full  = (count == (PTR_W+1)'(DEPTH));

	always_ff @(posedge clk) begin
		if (push) mem[wptr] <= wdata;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (push) wptr <= (wptr == PTR_W'(DEPTH-1)) ? '0 : wptr + 1'b1;
			if (pop)  rptr <= (rptr == PTR_W'(DEPTH-1)) ? '0 : rptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

	a_no_overflow:  assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

// ==== verilog/mxv_pe.sv ====
`timescale 1ns/1ps

// one stage of the systolic line
module mxv_pe
import mxv_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       en_in,
	input  elem_t      vec_in,
	input  elem_t      mat_in,
	output logic       en_out,   // skewed enable to next pe
	output elem_t      vec_out,  // vector pass register
	output pe_result_t result
);

	acc_t acc;
	acc_t prod;

	assign prod = acc_t'(mat_in) * acc_t'(vec_in);  // 255*255 still fits

	// enable skew, one cycle per stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			en_out <= 1'b0;
		end else begin
			en_out <= en_in;
		end
	end

	always_ff @(posedge clk) begin
		vec_out <= vec_in;  // free running
	end

	// MAC, first element after an idle cycle starts a fresh sum
	always_ff @(posedge clk) begin
		if (en_in) begin
			acc <= en_out ? acc + prod : prod;  // wraps at 16 bits
		end
	end

	// falling edge of en_in, sum is complete
	assign result.valid = en_out && !en_in;
	assign result.acc   = acc;

endmodule

// ==== verilog/mxv_pe_array.sv ====
`timescale 1ns/1ps

module mxv_pe_array
import mxv_pkg::*;
#(
	parameter int DEPTH = 8
) (
	input  logic    clk,
	input  logic    rst_n,
	input  load_t   load,
	input  n_t      n,
	input  logic    busy,
	input  logic    feed_en,
	input  row_t    feed_idx,   // step count, indexes the vector
	input  logic    round_sel,
	output res_wr_t res_wr
);

	elem_t      vbuf [DEPTH];  // vector, replayed in round 1
	row_t       vwptr;
	logic [N_MAX-1:0] row_push, row_pop;
	elem_t      row_data [N_MAX];

	logic       en_chain  [NUM_PE+1];  // [0] = feed, [k+1] = pe k out
	elem_t      vec_chain [NUM_PE+1];
	elem_t      pe_mat    [NUM_PE];
	row_t       pe_row    [NUM_PE];    // row worked on by pe k this round
	logic       row_ok    [NUM_PE];    // row below n
	pe_result_t pe_res    [NUM_PE];

	//////////////////////////////////////////////////
	// loading, only while idle
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n || busy) begin
			vwptr <= '0;  // next op starts at index 0
		end else if (load.push[N_MAX]) begin
			vwptr <= vwptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && load.push[N_MAX]) vbuf[vwptr] <= load.data;
	end

	assign row_push = load.push[N_MAX-1:0] & {N_MAX{!busy}};

	for (genvar r = 0; r < N_MAX; r++) begin : g_row
		mxv_row_fifo #(.DEPTH(DEPTH)) i_row_fifo (
			.clk   (clk),
			.rst_n (rst_n),
			.push  (row_push[r]),
			.pop   (row_pop[r]),
			.wdata (load.data),
			.rdata (row_data[r]),
			.empty (),  // load count is up to the host
			.full  ()
		);
	end

	//////////////////////////////////////////////////
	// systolic line
	//////////////////////////////////////////////////
	assign en_chain[0]  = feed_en;
	assign vec_chain[0] = vbuf[feed_idx];

	for (genvar k = 0; k < NUM_PE; k++) begin : g_pe
		assign pe_row[k] = row_t'(k) + (round_sel ? row_t'(NUM_PE) : row_t'(0));
		assign row_ok[k] = ({1'b0, pe_row[k]} < n);
		assign pe_mat[k] = row_data[pe_row[k]];  // round mux

		mxv_pe i_pe (
			.clk     (clk),
			.rst_n   (rst_n),
			.en_in   (en_chain[k]),
			.vec_in  (vec_chain[k]),
			.mat_in  (pe_mat[k]),
			.en_out  (en_chain[k+1]),
			.vec_out (vec_chain[k+1]),
			.result  (pe_res[k])
		);
	end

	// pop the active row of each pe, rows at or above n stay untouched
	always_comb begin
		row_pop = '0;
		for (int k = 0; k < NUM_PE; k++) begin
			if (en_chain[k] && row_ok[k]) row_pop[pe_row[k]] = 1'b1;
		end
	end

	// result demux into one ram write
	always_comb begin
		res_wr = '0;
		for (int k = 0; k < NUM_PE; k++) begin
			if (pe_res[k].valid && row_ok[k]) begin
				res_wr.we   = 1'b1;
				res_wr.addr = pe_row[k];
				res_wr.data = pe_res[k].acc;
			end
		end
	end

	// skew keeps results apart
	a_one_result: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({pe_res[3].valid, pe_res[2].valid, pe_res[1].valid, pe_res[0].valid}));

	// line fully drained past pe 0 when the round switches
	a_drained_at_switch: assert property (@(posedge clk) disable iff (!rst_n)
		$changed(round_sel) |-> !(en_chain[1] || en_chain[2] || en_chain[3] || en_chain[NUM_PE]));

endmodule

// ==== verilog/mxv_result_ram.sv ====
`timescale 1ns/1ps

// one write port, one registered read port
module mxv_result_ram
import mxv_pkg::*;
#(
	parameter int DEPTH = 8
) (
	input  logic    clk,
	input  res_wr_t wr,
	input  row_t    raddr,
	output acc_t    rdata
);

	acc_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr.we) begin
			mem[wr.addr] <= wr.data;
		end
		rdata <= mem[raddr];  // one cycle after the address
	end

endmodule

// ==== verilog/matrix_x_vector.sv ====
`timescale 1ns/1ps

module matrix_x_vector
import mxv_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  start,
	input  load_t load,
	input  n_t    n,      // stable from load until done
	output logic  busy,
	output tx_t   tx,
	output logic  done
);

	localparam int STEP_W = $bits(n_t);    // up to n+3 = 11
	localparam int READ_W = $bits(row_t);  // up to n-1 = 7

	n_t      step_count, step_term;
	row_t    read_count, read_term;
	logic    step_en, step_clr, step_done;
	logic    read_en, read_clr, read_done;
	logic    feed_en, round_sel, tx_valid;
	res_wr_t res_wr;
	acc_t    ram_rdata;

	assign step_term = n + n_t'(3);        // last result of a round
	assign read_term = row_t'(n - 1'b1);   // last row to send

	//////////////////////////////////////////////////
	// sequencing
	//////////////////////////////////////////////////
	mxv_control i_control (
		.clk (clk), .rst_n (rst_n), .start (start), .n (n),
		.step_count (step_count), .step_done (step_done), .read_done (read_done),
		.step_en (step_en), .step_clr (step_clr), .read_en (read_en), .read_clr (read_clr),
		.feed_en (feed_en), .round_sel (round_sel), .busy (busy),
		.tx_valid (tx_valid), .done (done)
	);

	mxv_counter #(.WIDTH(STEP_W)) i_step_counter (
		.clk (clk), .rst_n (rst_n), .en (step_en), .clr (step_clr),
		.terminal (step_term), .count (step_count), .at_terminal (step_done)
	);

	mxv_counter #(.WIDTH(READ_W)) i_read_counter (  // count is the ram read address
		.clk (clk), .rst_n (rst_n), .en (read_en), .clr (read_clr),
		.terminal (read_term), .count (read_count), .at_terminal (read_done)
	);

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////
	mxv_pe_array #(.DEPTH(N_MAX)) i_pe_array (
		.clk (clk), .rst_n (rst_n), .load (load), .n (n), .busy (busy),
		.feed_en (feed_en), .feed_idx (row_t'(step_count)), .round_sel (round_sel),
		.res_wr (res_wr)
	);

	mxv_result_ram #(.DEPTH(N_MAX)) i_result_ram (
		.clk (clk), .wr (res_wr), .raddr (read_count), .rdata (ram_rdata)
	);

	assign tx.valid = tx_valid;   // no back-pressure
	assign tx.data  = ram_rdata;

endmodule

// ==== testbench/tb_matrix_x_vector.sv ====
`timescale 1ns/1ps

module tb_matrix_x_vector
import mxv_pkg::*;
();

	// worst case per op: two rounds, send, full load
	localparam int OP_CYCLES   = 2*(N_MAX+4) + N_MAX+4 + N_MAX*9;
	localparam int NUM_OPS     = 25;
	localparam int WATCHDOG_NS = NUM_OPS*OP_CYCLES*20 + 10*OP_CYCLES*20;

	logic  clk, rst_n, start;
	load_t load;
	n_t    n;
	logic  busy, done;
	tx_t   tx;

	integer seed;
	elem_t  mat [N_MAX][N_MAX];
	elem_t  vec [N_MAX];
	acc_t   expected [N_MAX];  // reference results, row order
	int     errors, tests, failed_tests, err0;

	matrix_x_vector i_matrix_x_vector (
		.clk (clk), .rst_n (rst_n), .start (start), .load (load), .n (n),
		.busy (busy), .tx (tx), .done (done)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;  // 20 ns period

	//////////////////////////////////////////////////
	// operands and model
	//////////////////////////////////////////////////
	task automatic fill_random(input int order);
		for (int r = 0; r < order; r++) begin
			for (int c = 0; c < order; c++) mat[r][c] = elem_t'($random(seed));
			vec[r] = elem_t'($random(seed));
		end
	endtask

	task automatic fill_const(input int order, input elem_t value);
		for (int r = 0; r < order; r++) begin
			for (int c = 0; c < order; c++) mat[r][c] = value;
			vec[r] = value;
		end
	endtask

	// dot product per row, 16-bit wrap
	task automatic compute_expected(input int order);
		acc_t sum;
		for (int r = 0; r < order; r++) begin
			sum = '0;
			for (int c = 0; c < order; c++) sum = sum + acc_t'(mat[r][c]) * acc_t'(vec[c]);
			expected[r] = sum;
		end
	endtask

	// one byte per cycle, rows first then the vector
	task automatic load_operands(input int order);
		@(negedge clk);
		n = n_t'(order);  // held until done
		for (int r = 0; r <= order; r++) begin
			for (int c = 0; c < order; c++) begin
				@(negedge clk);
				load.push = '0;
				load.push[(r == order) ? N_MAX : r] = 1'b1;  // last pass is the vector
				load.data = (r == order) ? vec[c] : mat[r][c];
			end
		end
		@(negedge clk);
		load = '0;
	endtask

	//////////////////////////////////////////////////
	// one operation: load, start, collect, check
	//////////////////////////////////////////////////
	task automatic run_op(input string name, input int order, input bit restart);
		int cycles, got, first_valid, latency;
		bit seen_done;
		compute_expected(order);
		load_operands(order);
		latency = ((order > NUM_PE) ? 2 : 1) * (order + 4) + 2;  // rounds + ram read
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		cycles = 1;
		got = 0;
		first_valid = 0;
		seen_done = 1'b0;
		while (!seen_done && cycles <= OP_CYCLES) begin
			// outputs settled since the last rising edge
			if (tx.valid) begin
				if (got == 0) first_valid = cycles;
				if (got < order) begin
					assert (tx.data == expected[got]) else begin
						$display("** Error: %s row %0d expected %0d actual %0d",
							name, got, expected[got], tx.data);
						errors++;
					end
				end
				got++;
			end
			if (done) begin
				seen_done = 1'b1;
				assert (!busy) else begin
					$display("%s: busy still high in the done cycle", name);
					errors++;
				end
			end else begin
				assert (busy) else begin
					$display("%s: busy low before done at cycle %0d", name, cycles);
					errors++;
				end
			end
			start = restart && (cycles == 3);  // second start mid-run
			@(negedge clk);
			cycles++;
		end
		start = 1'b0;
		assert (seen_done) else begin
			$display("%s: no done within %0d cycles", name, OP_CYCLES);
			errors++;
		end
		assert (got == order) else begin
			$display("%s: %0d results arrived instead of %0d", name, got, order);
			errors++;
		end
		assert (first_valid == latency) else begin
			$display("%s: first result at cycle %0d instead of %0d", name, first_valid, latency);
			errors++;
		end
		assert (!done && !tx.valid) else begin
			$display("%s: done or valid still high after the done pulse", name);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors != err_before) failed_tests++;
		$display("%-22s %s, %0d errors", name,
			(errors == err_before) ? "ok" : "failed", errors - err_before);
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////
	initial begin
		seed         = 19861;
		errors       = 0;
		tests        = 0;
		failed_tests = 0;
		rst_n        = 1'b0;
		start        = 1'b0;
		load         = '0;
		n            = n_t'(1);
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		assert (!busy && !tx.valid && !done) else begin
			$display("outputs not idle after reset");
			errors++;
		end

		err0 = errors;  // both rounds
		fill_random(8);
		run_op("full_n8", 8, 1'b0);
		report_test("full_n8", err0);

		err0 = errors;  // round 0 only
		fill_random(4);
		run_op("single_round_n4", 4, 1'b0);
		report_test("single_round_n4", err0);

		err0 = errors;
		fill_random(1);
		run_op("smallest_n1", 1, 1'b0);
		report_test("smallest_n1", err0);

		err0 = errors;  // fifos and vector buffer must start clean
		for (int i = 0; i < 20; i++) begin
			int order;
			order = 1 + ($unsigned($random(seed)) % N_MAX);
			fill_random(order);
			run_op("back_to_back", order, 1'b0);
		end
		report_test("back_to_back", err0);

		err0 = errors;
		fill_random(6);
		run_op("start_while_busy", 6, 1'b1);
		report_test("start_while_busy", err0);

		err0 = errors;  // 8*65025 wraps
		fill_const(8, 8'hff);
		run_op("wrap_around", 8, 1'b0);
		report_test("wrap_around", err0);

		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// watchdog, sized from the op count
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== matrix_x_vector.f ====
verilog/mxv_pkg.sv
verilog/mxv_counter.sv
verilog/mxv_control.sv
verilog/mxv_row_fifo.sv
verilog/mxv_pe.sv
verilog/mxv_pe_array.sv
verilog/mxv_result_ram.sv
verilog/matrix_x_vector.sv
testbench/tb_matrix_x_vector.sv

// ==== Bender.yml ====
package:
  name: matrix_x_vector

sources:
  - verilog/mxv_pkg.sv
  - verilog/mxv_counter.sv
  - verilog/mxv_control.sv
  - verilog/mxv_row_fifo.sv
  - verilog/mxv_pe.sv
  - verilog/mxv_pe_array.sv
  - verilog/mxv_result_ram.sv
  - verilog/matrix_x_vector.sv
  - target: simulation
    files:
      - testbench/tb_matrix_x_vector.sv
